//--- build.f
design/fft_num_pkg.sv
design/fft_stream_pkg.sv
design/fft_butterfly.sv
design/fft_stage.sv
design/fft_frame_loader.sv
design/fft_top.sv
verif/fft_clock_gen.sv
verif/fft_assertions.sv
verif/fft_tb.sv

//--- Makefile
TOOL       ?= verilator
TOP        ?= fft_tb
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FLAGS      ?= --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS ?= --lint-only --timing -Wall
RUN_FLAGS  ?= +verilator+error+limit+1000
FAIL_MSG   := test failed
PASS_MSG   := test passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/fft_tb.sv
`timescale 1ns/1ps

module fft_tb;

  typedef enum logic [1:0] {
    kind_impulse,
    kind_dc,
    kind_alt,
    kind_cos
  } frame_kind_t;

  localparam int frames_total    = 40;  // 2 + 2 + 24 + 12
  localparam int watchdog_cycles = 40 * frames_total + 200;
  localparam int tolerance       = 4;   // LSB
  localparam int drain_limit     = 100;  // cycles

  logic                        clk;
  logic                        rst;
  fft_stream_pkg::real_frame_t in_frame;
  logic                        in_val;
  logic                        in_rdy;
  fft_stream_pkg::cplx_frame_t out_frame;
  logic                        out_val;
  logic                        out_rdy;

  fft_stream_pkg::cplx_frame_t exp_q [$];
  fft_stream_pkg::cplx_frame_t pending_exp;  // spectrum of whatever sits on in_frame
  fft_stream_pkg::cplx_frame_t head_exp;
  logic                        stall_mode;
  int unsigned                 rdy_state;
  int unsigned                 gen_state;
  int                          cmp_errors;
  int                          frames_checked;
  int                          total_errors;

  fft_clock_gen clk_gen_i (
    .clk(clk),
    .rst(rst)
  );

  fft_top dut_i (
    .clk      (clk),
    .rst      (rst),
    .in_frame (in_frame),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .out_frame(out_frame),
    .out_val  (out_val),
    .out_rdy  (out_rdy)
  );

  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // cos(2*pi*n/8) over the full circle from the half-circle table
  function automatic fft_num_pkg::fx_t cos_sample(input int n);
    if (n < 4) begin
      return fft_num_pkg::tw_cos[n];
    end
    return -fft_num_pkg::tw_cos[n-4];
  endfunction

  function automatic fft_stream_pkg::real_frame_t build_frame(input frame_kind_t kind,
                                                              input fft_num_pkg::fx_t amp);
    fft_stream_pkg::real_frame_t f;
    for (int n = 0; n < fft_num_pkg::n_samples; n++) begin
      case (kind)
        kind_impulse: f[n] = (n == 0) ? amp : '0;
        kind_dc:      f[n] = amp;
        kind_alt:     f[n] = (n % 2 != 0) ? -amp : amp;
        default:      f[n] = (amp >>> fft_num_pkg::frac_bits) * cos_sample(n);  // integer amp
      endcase
    end
    return f;
  endfunction

  // closed-form spectra of the four test signals
  function automatic fft_stream_pkg::cplx_frame_t expected_spectrum(
    input frame_kind_t kind,
    input fft_num_pkg::fx_t amp
  );
    fft_stream_pkg::cplx_frame_t s;
    s = '0;
    case (kind)
      kind_impulse: begin
        for (int b = 0; b < fft_num_pkg::n_samples; b++) begin
          s[b].re = amp;
        end
      end
      kind_dc:  s[0].re = amp * 8;
      kind_alt: s[4].re = amp * 8;
      default: begin
        s[1].re = amp * 4;
        s[7].re = amp * 4;
      end
    endcase
    return s;
  endfunction

  task automatic check_value(input string name, input fft_num_pkg::fx_t exp_v,
                             input fft_num_pkg::fx_t act_v);
    longint diff;
    diff = longint'(act_v) - longint'(exp_v);
    if (diff > tolerance || diff < -tolerance) begin
      cmp_errors++;
      $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_frame(input fft_stream_pkg::cplx_frame_t exp_f,
                             input fft_stream_pkg::cplx_frame_t act_f);
    for (int b = 0; b < fft_num_pkg::n_samples; b++) begin
      check_value($sformatf("out_frame[%0d].re", b), exp_f[b].re, act_f[b].re);
      check_value($sformatf("out_frame[%0d].im", b), exp_f[b].im, act_f[b].im);
    end
  endtask

  // returns 1 ns after the accepting edge, in_val still high
  task automatic send_frame(input frame_kind_t kind, input fft_num_pkg::fx_t amp);
    in_frame    = build_frame(kind, amp);
    pending_exp = expected_spectrum(kind, amp);
    in_val      = 1'b1;
    @(posedge clk);
    while (!in_rdy) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic send_random_frame();
    frame_kind_t      kind;
    fft_num_pkg::fx_t amp;
    int unsigned      r;
    gen_state = lcg_step(gen_state);
    kind      = frame_kind_t'((gen_state >> 16) % 4);
    gen_state = lcg_step(gen_state);
    if (kind == kind_cos) begin
      r   = (gen_state >> 16) % 4;
      amp = fft_num_pkg::fx_t'((r + 1) << fft_num_pkg::frac_bits);  // 1.0 to 4.0
    end else begin
      amp = fft_num_pkg::fx_t'(int'((gen_state >> 8) % 32'd524288) - 262144);  // +-4.0
    end
    send_frame(kind, amp);
  endtask

  task automatic idle(input int cycles);
    in_val = 1'b0;
    repeat (cycles) @(posedge clk);
    #1;
  endtask

  // a lost frame leaves the queue filled for the final check
  task automatic drain();
    int waited;
    in_val = 1'b0;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
  endtask

  //////////////////////////////////////////////////
  // scoreboard
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst) begin
      if (out_val && out_rdy) begin
        if (exp_q.size() == 0) begin
          cmp_errors++;
          $display("output frame at %0t arrived while no frame was expected", $time);
        end else begin
          head_exp = exp_q.pop_front();
          check_frame(head_exp, out_frame);
          frames_checked++;
        end
      end
      if (in_val && in_rdy) begin
        exp_q.push_back(pending_exp);
      end
    end
  end

  // output back-pressure, mode sampled on the edge
  initial begin
    logic stall_now;
    forever begin
      @(posedge clk);
      stall_now = stall_mode;
      #1;
      if (stall_now) begin
        rdy_state = lcg_step(rdy_state);
        out_rdy   = ((rdy_state >> 16) % 3) == 0;  // ready about one cycle in three
      end else begin
        out_rdy = 1'b1;
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles with frames still pending", watchdog_cycles);
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    in_frame       = '0;
    in_val         = 1'b0;
    out_rdy        = 1'b1;
    pending_exp    = '0;
    stall_mode     = 1'b0;
    rdy_state      = 32'd49551;
    gen_state      = 32'd49551;
    cmp_errors     = 0;
    frames_checked = 0;

    @(negedge rst);
    @(posedge clk);
    #1;

    send_frame(kind_impulse, 32'sd98304);  // 1.5
    idle(3);
    send_frame(kind_dc, -32'sd32768);
    drain();

    send_frame(kind_alt, 32'sd49152);
    idle(2);
    send_frame(kind_cos, 32'sd131072);  // every twiddle value
    drain();

    stall_mode = 1'b1;
    for (int f = 0; f < 24; f++) begin
      send_random_frame();
      gen_state = lcg_step(gen_state);
      if ((gen_state >> 16) % 3 != 0) begin
        idle((gen_state >> 20) % 3);
      end
    end
    drain();
    stall_mode = 1'b0;
    idle(2);

    // back to back, one frame per cycle
    for (int f = 0; f < 12; f++) begin
      send_random_frame();
    end
    drain();
    idle(4);

    if (exp_q.size() != 0) begin
      cmp_errors++;
      $display("%0d expected frames never came out", exp_q.size());
    end
    total_errors = cmp_errors + dut_i.asrt_i.fail_count;
    $display("errors: %0d total, %0d compare, %0d assertion, %0d frames checked",
             total_errors, cmp_errors, dut_i.asrt_i.fail_count, frames_checked);
    if (total_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verif/fft_assertions.sv
`timescale 1ns/1ps

module fft_assertions (
  input logic                        clk,
  input logic                        rst,
  input fft_stream_pkg::real_frame_t in_frame,
  input logic                        in_val,
  input logic                        in_rdy,
  input fft_stream_pkg::cplx_frame_t out_frame,
  input logic                        out_val,
  input logic                        out_rdy
);

  int fail_count = 0;  // read by the testbench summary

  //////////////////////////////////////////////////
  // reset
  //////////////////////////////////////////////////

  // covers reset and the first cycle after it
  a_reset_idle: assert property (@(posedge clk) $past(rst) |-> !out_val && in_rdy)
    else begin
      fail_count++;
      $error("out_val high or in_rdy low during or right after reset");
    end

  //////////////////////////////////////////////////
  // stream handshakes
  //////////////////////////////////////////////////

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_val && !out_rdy |=> out_val && $stable(out_frame))
    else begin
      fail_count++;
      $error("stalled output frame changed or out_val dropped");
    end

  // a held frame waits in a full pipe and gets in as soon as the output moves
  a_in_hold: assert property (@(posedge clk) disable iff (rst)
    in_val && !in_rdy |=> in_val && $stable(in_frame) && (in_rdy == out_rdy))
    else begin
      fail_count++;
      $error("held input frame changed or in_rdy did not follow out_rdy");
    end

  // only a full pipe behind a stalled output may refuse input
  a_rdy_low: assert property (@(posedge clk) disable iff (rst)
    !in_rdy |-> out_val && !out_rdy)
    else begin
      fail_count++;
      $error("in_rdy low while the output is not stalled");
    end

  // four register slots, four cycles with a free path
  a_latency: assert property (@(posedge clk) disable iff (rst)
    $past(in_val && in_rdy, 4) && $past(out_rdy, 3) && $past(out_rdy, 2) &&
    $past(out_rdy, 1) |-> out_val)
    else begin
      fail_count++;
      $error("frame not at the output 4 cycles after acceptance");
    end

endmodule

bind fft_top fft_assertions asrt_i (
  .clk      (clk),
  .rst      (rst),
  .in_frame (in_frame),
  .in_val   (in_val),
  .in_rdy   (in_rdy),
  .out_frame(out_frame),
  .out_val  (out_val),
  .out_rdy  (out_rdy)
);

//--- verif/fft_clock_gen.sv
`timescale 1ns/1ps

module fft_clock_gen (
  output logic clk,
  output logic rst
);

  localparam int half_period  = 4;  // 8 ns clock
  localparam int reset_cycles = 5;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // release 1 ns after the last reset edge, like every other input
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

//--- design/fft_top.sv
`timescale 1ns/1ps

module fft_top (
  input  logic                        clk,
  input  logic                        rst,

  input  fft_stream_pkg::real_frame_t in_frame,
  input  logic                        in_val,
  output logic                        in_rdy,

  output fft_stream_pkg::cplx_frame_t out_frame,
  output logic                        out_val,
  input  logic                        out_rdy
);

  // link 0 leaves the loader, link k+1 leaves stage k
  fft_stream_pkg::cplx_frame_t link_frame [fft_num_pkg::n_stages+1];
  logic                        link_val   [fft_num_pkg::n_stages+1];
  logic                        link_rdy   [fft_num_pkg::n_stages+1];

  fft_frame_loader loader_i (
    .clk      (clk),
    .rst      (rst),
    .in_frame (in_frame),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .out_frame(link_frame[0]),
    .out_val  (link_val[0]),
    .out_rdy  (link_rdy[0])
  );

  generate
    for (genvar s = 0; s < fft_num_pkg::n_stages; s++) begin : g_stage
      fft_stage #(
        .stage_idx(s)
      ) stage_i (
        .clk      (clk),
        .rst      (rst),
        .in_frame (link_frame[s]),
        .in_val   (link_val[s]),
        .in_rdy   (link_rdy[s]),
        .out_frame(link_frame[s+1]),
        .out_val  (link_val[s+1]),
        .out_rdy  (link_rdy[s+1])
      );
    end
  endgenerate

  assign out_frame                      = link_frame[fft_num_pkg::n_stages];
  assign out_val                        = link_val[fft_num_pkg::n_stages];
  assign link_rdy[fft_num_pkg::n_stages] = out_rdy;

endmodule

//--- design/fft_frame_loader.sv
`timescale 1ns/1ps

module fft_frame_loader (
  input  logic                        clk,
  input  logic                        rst,

  input  fft_stream_pkg::real_frame_t in_frame,
  input  logic                        in_val,
  output logic                        in_rdy,

  output fft_stream_pkg::cplx_frame_t out_frame,
  output logic                        out_val,
  input  logic                        out_rdy
);

  fft_stream_pkg::cplx_frame_t load_frame;
  fft_stream_pkg::cplx_frame_t frame_q;
  logic                        full;

  // mirror the n_stages index bits
  function automatic int bitrev(input int idx);
    int rev;
    rev = 0;
    for (int b = 0; b < fft_num_pkg::n_stages; b++) begin
      rev = (rev << 1) | ((idx >> b) & 1);
    end
    return rev;
  endfunction

  always_comb begin
    for (int i = 0; i < fft_num_pkg::n_samples; i++) begin
      load_frame[bitrev(i)].re = in_frame[i];
      load_frame[bitrev(i)].im = '0;  // real input
    end
  end

  //////////////////////////////////////////////////
  // input slot, same handshake as a stage
  //////////////////////////////////////////////////

  assign in_rdy = !full || out_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_val && in_rdy) begin
      full <= 1'b1;
    end else if (out_rdy) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      frame_q <= load_frame;
    end
  end

  assign out_frame = frame_q;
  assign out_val   = full;

endmodule

//--- design/fft_stage.sv
`timescale 1ns/1ps

module fft_stage #(
  parameter int stage_idx = 0
) (
  input  logic                        clk,
  input  logic                        rst,

  input  fft_stream_pkg::cplx_frame_t in_frame,
  input  logic                        in_val,
  output logic                        in_rdy,

  output fft_stream_pkg::cplx_frame_t out_frame,
  output logic                        out_val,
  input  logic                        out_rdy
);

  localparam int span    = 1 << stage_idx;  // distance between the two legs
  localparam int tw_step = fft_num_pkg::n_samples / (2 * span);

  wire fft_stream_pkg::cplx_frame_t bfly_frame;  // one driver per leg

  fft_stream_pkg::cplx_frame_t frame_q;
  logic                        full;

  //////////////////////////////////////////////////
  // butterflies
  //////////////////////////////////////////////////

  generate
    for (genvar j = 0; j < fft_num_pkg::n_samples / 2; j++) begin : g_bfly
      localparam int pos = j % span;                      // place inside its group
      localparam int lo  = (j / span) * 2 * span + pos;
      localparam int hi  = lo + span;
      localparam int k   = pos * tw_step;                 // twiddle index

      fft_butterfly bfly_i (
        .a    (in_frame[lo]),
        .b    (in_frame[hi]),
        .tw_re(fft_num_pkg::tw_cos[k]),
        .tw_im(fft_num_pkg::tw_sin[k]),
        .top  (bfly_frame[lo]),
        .bot  (bfly_frame[hi])
      );
    end
  endgenerate

  //////////////////////////////////////////////////
  // output slot
  //////////////////////////////////////////////////

  // a full slot can take a new frame in the same cycle the old one leaves
  assign in_rdy = !full || out_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_val && in_rdy) begin
      full <= 1'b1;
    end else if (out_rdy) begin
      full <= 1'b0;  // drained, nothing behind it
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      frame_q <= bfly_frame;
    end
  end

  assign out_frame = frame_q;
  assign out_val   = full;

endmodule

//--- design/fft_butterfly.sv
`timescale 1ns/1ps

module fft_butterfly (
  input  fft_num_pkg::cplx_t a,
  input  fft_num_pkg::cplx_t b,
  input  fft_num_pkg::fx_t   tw_re,
  input  fft_num_pkg::fx_t   tw_im,
  output fft_num_pkg::cplx_t top,
  output fft_num_pkg::cplx_t bot
);

  typedef logic signed [2*fft_num_pkg::word_width-1:0] wide_t;

  fft_num_pkg::fx_t t_re;
  fft_num_pkg::fx_t t_im;

  // full 64-bit product, round to nearest, back to Q16.16
  function automatic fft_num_pkg::fx_t fx_mul(
    input fft_num_pkg::fx_t x,
    input fft_num_pkg::fx_t y
  );
    wide_t prod;
    prod = x * y;
    prod = prod + (wide_t'(1) <<< (fft_num_pkg::frac_bits - 1));  // half LSB
    return fft_num_pkg::fx_t'(prod >>> fft_num_pkg::frac_bits);
  endfunction

  // t = b * (tw_re - j*tw_im)
  always_comb begin
    t_re = fx_mul(b.re, tw_re) + fx_mul(b.im, tw_im);
    t_im = fx_mul(b.im, tw_re) - fx_mul(b.re, tw_im);
  end

  // no growth guard, caller keeps inputs small
  always_comb begin
    top.re = a.re + t_re;
    top.im = a.im + t_im;
    bot.re = a.re - t_re;
    bot.im = a.im - t_im;
  end

endmodule

//--- design/fft_stream_pkg.sv
package fft_stream_pkg;

  //////////////////////////////////////////////////
  // frames moving over the valid/ready links
  //////////////////////////////////////////////////

  // real samples as delivered by the caller, sample i in element i
  typedef fft_num_pkg::fx_t [fft_num_pkg::n_samples-1:0] real_frame_t;

  // complex frame between loader, stages and the output port
  // element i holds bin i once the last stage is done
  typedef fft_num_pkg::cplx_t [fft_num_pkg::n_samples-1:0] cplx_frame_t;

endpackage

//--- design/fft_num_pkg.sv
package fft_num_pkg;

  //////////////////////////////////////////////////
  // transform size
  //////////////////////////////////////////////////

  localparam int n_samples = 8;
  localparam int n_stages  = $clog2(n_samples);  // 3 for 8 points

  //////////////////////////////////////////////////
  // fixed-point format
  //////////////////////////////////////////////////

  localparam int word_width = 32;
  localparam int frac_bits  = 16;  // Q16.16

  typedef logic signed [word_width-1:0] fx_t;

  typedef struct packed {
    fx_t re;
    fx_t im;
  } cplx_t;

  //////////////////////////////////////////////////
  // twiddle factors
  //////////////////////////////////////////////////

  // W8^k = cos(2*pi*k/8) - j*sin(2*pi*k/8)
  // only the first half of the circle is used by a DIT butterfly
  localparam fx_t tw_cos [n_samples/2] = '{
    32'sd65536,   // 1.0
    32'sd46341,   // 1/sqrt(2)
    32'sd0,
    -32'sd46341
  };

  localparam fx_t tw_sin [n_samples/2] = '{
    32'sd0,
    32'sd46341,
    32'sd65536,
    32'sd46341
  };

endpackage
